/* dv/depth_stream_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module depth_stream_sva (
    input wire                                 core_clk,
    input wire                                 sys_reset,
    input wire [depth_stream_pkg::PIXEL_W-1:0] byte_i,
    input wire                                 byte_valid_i,
    input wire                                 byte_stall_i,
    input wire                                 overflow_i
);

    // a stalled byte stays on the bus untouched
    hold_while_stalled: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        (byte_valid_i && byte_stall_i) |=> ($stable(byte_i) && $stable(byte_valid_i))
    ) else $error("output byte or valid changed while stalled");

    reset_clears_outputs: assert property (
        @(posedge core_clk)
        sys_reset |=> (!byte_valid_i && !overflow_i)
    ) else $error("byte_valid_o or overflow_o high after a reset cycle");

    // lost pixels stay flagged until the next reset
    overflow_is_sticky: assert property (
        @(posedge core_clk)
        (overflow_i && !sys_reset) |=> overflow_i
    ) else $error("overflow_o dropped without a reset");

endmodule

bind depth_stream_top depth_stream_sva u_depth_stream_sva (
    .core_clk    (core_clk),
    .sys_reset   (sys_reset),
    .byte_i      (byte_o),
    .byte_valid_i(byte_valid_o),
    .byte_stall_i(byte_stall_i),
    .overflow_i  (overflow_o)
);

`default_nettype wire

/* dv/depth_stream_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module depth_stream_tb;

    localparam int unsigned SEED       = 32'h074f5023;
    localparam logic [63:0] HEADER     = "BIVFRAME";
    localparam logic [15:0] REG_WIDTH  = 16'h0001;
    localparam logic [15:0] REG_HEIGHT = 16'h0002;
    localparam logic [15:0] REG_GAIN   = 16'h0003;
    localparam int          WAIT_LIMIT = 2000;

    logic       core_clk;
    logic       sys_reset;
    logic [7:0] cmd_byte_i;
    logic       cmd_valid_i;
    logic [7:0] plus_i;
    logic [7:0] minus_i;
    logic       pix_valid_i;
    logic       pix_sof_i;
    logic       byte_stall_i;
    logic [7:0] byte_o;
    logic       byte_valid_o;
    logic       overflow_o;

    ////////////////////////////////////////
    // reference model state
    logic [7:0]  exp_q[$];
    int          model_col;
    int          model_row;
    int          model_width;
    int          model_height;
    int          model_gain;
    int          model_bytes;

    int          rx_count;
    bit          check_all;
    int          stall_mode;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          test_errors_base;

    depth_stream_top dut (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .cmd_byte_i  (cmd_byte_i),
        .cmd_valid_i (cmd_valid_i),
        .plus_i      (plus_i),
        .minus_i     (minus_i),
        .pix_valid_i (pix_valid_i),
        .pix_sof_i   (pix_sof_i),
        .byte_o      (byte_o),
        .byte_valid_o(byte_valid_o),
        .byte_stall_i(byte_stall_i),
        .overflow_o  (overflow_o)
    );

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    // stall mode 0 is off, 1 holds the stall high and 2 makes it random
    initial begin
        int mode;
        byte_stall_i = 1'b0;
        forever begin
            @(posedge core_clk);
            mode = stall_mode;
            #2;
            if (mode == 2) begin
                byte_stall_i = ($urandom_range(0, 2) == 0);
            end else begin
                byte_stall_i = (mode == 1);
            end
        end
    end

    // each transfer compared in order at the falling edge
    initial begin
        logic [7:0] expected;
        forever begin
            @(negedge core_clk);
            if (byte_valid_o && !byte_stall_i) begin
                rx_count++;
                if (exp_q.size() == 0) begin
                    if (check_all) begin
                        $display("unexpected byte %02h at %0t, the model expects nothing",
                                 byte_o, $time);
                        error_count++;
                    end
                end else begin
                    expected = exp_q.pop_front();
                    if (check_all || rx_count <= 8) begin
                        check_value("byte_o", 32'(byte_o), 32'(expected));
                    end
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge core_clk);
        #2;
    endtask

    function automatic logic [7:0] random_byte();
        return 8'($urandom_range(0, 255));
    endfunction

    task automatic begin_test();
        rx_count         = 0;
        model_bytes      = 0;
        test_errors_base = error_count;
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("%s: done at %0t, %0d failures", name, $time, error_count - test_errors_base);
    endtask

    task automatic apply_reset();
        sys_reset = 1'b1;
        repeat (4) next_cycle();
        sys_reset = 1'b0;
        exp_q.delete();
        model_col    = 0;
        model_row    = 0;
        model_width  = 490;
        model_height = 450;
        model_gain   = 16;
    endtask

    task automatic write_register(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] word;
        int          i;
        word = {addr, data};
        for (i = 0; i < 6; i++) begin
            // address high byte first
            cmd_byte_i  = word[47 - 8*i -: 8];
            cmd_valid_i = 1'b1;
            next_cycle();
        end
        cmd_valid_i = 1'b0;
        repeat (3) next_cycle();
        case (addr)
            REG_WIDTH:  model_width  = int'(data[15:0]);
            REG_HEIGHT: model_height = int'(data[15:0]);
            REG_GAIN:   model_gain   = int'(data[7:0]);
            default: begin
            end
        endcase
    endtask

    ////////////////////////////////////////
    // expected bytes for one accepted pixel
    task automatic model_pixel(input logic [7:0] p, input logic [7:0] m, input bit sof);
        int diff;
        int value;
        int k;
        if (sof) begin
            model_col = 0;
            model_row = 0;
        end
        if (model_col == 0 && model_row == 0) begin
            for (k = 0; k < 8; k++) begin
                exp_q.push_back(HEADER[63 - 8*k -: 8]);
            end
            model_bytes += 8;
        end
        diff  = (p > m) ? int'(p) - int'(m) : int'(m) - int'(p);
        value = (diff * model_gain) >> 4;
        if (value > 255) begin
            value = 255;
        end
        exp_q.push_back(value[7:0]);
        model_bytes++;
        // raster walk through the region
        if (model_col == model_width - 1) begin
            model_col = 0;
            model_row = (model_row == model_height - 1) ? 0 : model_row + 1;
        end else begin
            model_col++;
        end
    endtask

    task automatic send_pixel(input logic [7:0] p, input logic [7:0] m, input bit sof,
                              input int gap);
        plus_i      = p;
        minus_i     = m;
        pix_sof_i   = sof;
        pix_valid_i = 1'b1;
        model_pixel(p, m, sof);
        next_cycle();
        pix_valid_i = 1'b0;
        pix_sof_i   = 1'b0;
        repeat (gap) next_cycle();
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s: %0d expected bytes never came out", what, exp_q.size());
            error_count++;
        end
        // catch a stray trailing byte
        repeat (4) next_cycle();
    endtask

    task automatic wait_output_idle(input string what);
        int cycles;
        cycles = 0;
        while (byte_valid_o && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (byte_valid_o) begin
            $display("timeout in %s: output never went idle", what);
            error_count++;
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    task automatic verify_idle_after_reset(input string name);
        begin_test();
        apply_reset();
        check_value("byte_valid_o", 32'(byte_valid_o), 32'd0);
        check_value("overflow_o", 32'(overflow_o), 32'd0);
        repeat (20) next_cycle();
        check_value("bytes out while idle", rx_count, 32'd0);
        report_test(name);
    endtask

    task automatic run_one_frame();
        int i;
        begin_test();
        write_register(REG_WIDTH, 32'd4);
        write_register(REG_HEIGHT, 32'd3);
        write_register(REG_GAIN, 32'd16);
        for (i = 0; i < 12; i++) begin
            send_pixel(random_byte(), random_byte(), i == 0, 0);
        end
        wait_drain("one frame");
        check_value("bytes out", rx_count, 32'd20);
        report_test("program and one frame");
    endtask

    task automatic exercise_gain_saturation();
        logic [7:0] plus_set [8];
        logic [7:0] minus_set [8];
        int         i;
        plus_set  = '{8'd255, 8'd0,   8'd70, 8'd10, 8'd100, 8'd3, 8'd128, 8'd1};
        minus_set = '{8'd0,   8'd200, 8'd6,  8'd73, 8'd90,  8'd3, 8'd64,  8'd200};
        begin_test();
        write_register(REG_GAIN, 32'd64);
        for (i = 0; i < 8; i++) begin
            send_pixel(plus_set[i], minus_set[i], i == 0, 0);
        end
        wait_drain("gain and saturation");
        // one header and eight pixels
        check_value("bytes out", rx_count, 32'd16);
        report_test("gain and saturation");
    endtask

    task automatic regenerate_frames();
        int i;
        begin_test();
        write_register(REG_GAIN, 32'd16);
        // one idle cycle per pixel leaves room for the headers
        for (i = 0; i < 36; i++) begin
            send_pixel(random_byte(), random_byte(), i == 0, 1);
        end
        // sof on the sixth pixel cuts the frame short
        for (i = 0; i < 10; i++) begin
            send_pixel(random_byte(), random_byte(), i == 5, 1);
        end
        wait_drain("frame regeneration");
        // 46 pixels and five headers
        check_value("bytes out", rx_count, 32'd86);
        report_test("frame regeneration");
    endtask

    task automatic stream_under_backpressure();
        int i;
        begin_test();
        stall_mode = 2;
        for (i = 0; i < 24; i++) begin
            send_pixel(random_byte(), random_byte(), i == 0, $urandom_range(2, 4));
        end
        wait_drain("back-pressure");
        stall_mode = 0;
        repeat (2) next_cycle();
        check_value("overflow_o", 32'(overflow_o), 32'd0);
        // two full frames with a header each
        check_value("bytes out", rx_count, 32'd40);
        report_test("back-pressure");
    endtask

    task automatic force_overflow();
        int i;
        begin_test();
        stall_mode = 1;
        check_all  = 1'b0;
        repeat (2) next_cycle();
        for (i = 0; i < 40; i++) begin
            send_pixel(random_byte(), random_byte(), i == 0, 0);
        end
        repeat (4) next_cycle();
        stall_mode = 0;
        wait_output_idle("overflow drain");
        check_value("overflow_o", 32'(overflow_o), 32'd1);
        check_value("bytes out below model", 32'(rx_count < model_bytes), 32'd1);
        exp_q.delete();
        check_all = 1'b1;
        report_test("overflow");
    endtask

    initial begin
        void'($urandom(SEED));
        sys_reset   = 1'b1;
        cmd_byte_i  = 8'h00;
        cmd_valid_i = 1'b0;
        plus_i      = 8'h00;
        minus_i     = 8'h00;
        pix_valid_i = 1'b0;
        pix_sof_i   = 1'b0;
        stall_mode  = 0;
        check_all   = 1'b1;

        verify_idle_after_reset("reset state");
        run_one_frame();
        exercise_gain_saturation();
        regenerate_frames();
        stream_under_backpressure();
        force_overflow();
        verify_idle_after_reset("final reset");

        $display("summary: %0d tests, %0d checks, %0d failures",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hdl/depth_stream_pkg.sv
hdl/command_assembler.sv
hdl/constants_regs.sv
hdl/pixel_position_tracker.sv
hdl/contrast_stage.sv
hdl/stream_fifo.sv
hdl/frame_serializer.sv
hdl/depth_stream_top.sv
dv/depth_stream_sva.sv
dv/depth_stream_tb.sv

/* hdl/command_assembler.sv */
`timescale 1ns/10ps
`default_nettype none

module command_assembler (
    input  wire                                   core_clk,
    input  wire                                   sys_reset,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0]  cmd_byte_i,
    input  wire                                   cmd_valid_i,
    output depth_stream_pkg::cmd_word_u           cmd_word_o,
    output logic                                  cmd_word_valid_o
);

    logic [depth_stream_pkg::CMD_CNT_W-1:0] byte_cnt_q;
    logic                                   last_byte;

    assign last_byte = cmd_valid_i && (byte_cnt_q == depth_stream_pkg::CMD_LAST);

    always_ff @(posedge core_clk) begin
        // first byte lands in the top of the word
        if (cmd_valid_i) begin
            cmd_word_o.bytes[byte_cnt_q] <= cmd_byte_i;
        end

        cmd_word_valid_o <= last_byte;

        if (last_byte) begin
            byte_cnt_q <= '0;
        end else if (cmd_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
        end

        // drop any half-received command
        if (sys_reset) begin
            byte_cnt_q       <= '0;
            cmd_word_valid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/constants_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module constants_regs (
    input  wire                                  core_clk,
    input  wire                                  sys_reset,
    input  depth_stream_pkg::cmd_word_u          cmd_word_i,
    input  wire                                  cmd_word_valid_i,
    output logic [depth_stream_pkg::COORD_W-1:0] roi_width_o,
    output logic [depth_stream_pkg::COORD_W-1:0] roi_height_o,
    output logic [depth_stream_pkg::GAIN_W-1:0]  gain_o
);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            roi_width_o  <= depth_stream_pkg::DEFAULT_ROI_WIDTH;
            roi_height_o <= depth_stream_pkg::DEFAULT_ROI_HEIGHT;
            gain_o       <= depth_stream_pkg::DEFAULT_GAIN;
        end else if (cmd_word_valid_i) begin
            // unknown addresses fall through untouched
            case (cmd_word_i.fields.addr)
                depth_stream_pkg::ADDR_ROI_WIDTH: begin
                    roi_width_o <= cmd_word_i.fields.data[depth_stream_pkg::COORD_W-1:0];
                end
                depth_stream_pkg::ADDR_ROI_HEIGHT: begin
                    roi_height_o <= cmd_word_i.fields.data[depth_stream_pkg::COORD_W-1:0];
                end
                depth_stream_pkg::ADDR_GAIN: begin
                    gain_o <= cmd_word_i.fields.data[depth_stream_pkg::GAIN_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/contrast_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module contrast_stage (
    input  wire                                  core_clk,
    input  wire                                  sys_reset,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] plus_i,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] minus_i,
    input  wire                                  valid_i,
    input  wire                                  frame_start_i,
    input  wire  [depth_stream_pkg::GAIN_W-1:0]  gain_i,
    output logic [depth_stream_pkg::PIXEL_W-1:0] byte_o,
    output logic                                 valid_o,
    output logic                                 frame_start_o
);

    logic [depth_stream_pkg::PIXEL_W-1:0]                          abs_diff;
    logic [depth_stream_pkg::PIXEL_W+depth_stream_pkg::GAIN_W-1:0] product;
    logic [depth_stream_pkg::PIXEL_W+depth_stream_pkg::GAIN_W-1:0] scaled;
    logic [depth_stream_pkg::PIXEL_W-1:0]                          sat_byte;

    always_comb begin
        abs_diff = (plus_i >= minus_i) ? (plus_i - minus_i) : (minus_i - plus_i);
        product  = abs_diff * gain_i;
        scaled   = product >> depth_stream_pkg::GAIN_FRAC;

        // anything above the low byte clips to full scale
        if (|scaled[depth_stream_pkg::PIXEL_W+depth_stream_pkg::GAIN_W-1:
                    depth_stream_pkg::PIXEL_W]) begin
            sat_byte = {depth_stream_pkg::PIXEL_W{1'b1}};
        end else begin
            sat_byte = scaled[depth_stream_pkg::PIXEL_W-1:0];
        end
    end

    always_ff @(posedge core_clk) begin
        byte_o        <= sat_byte;
        valid_o       <= valid_i;
        frame_start_o <= valid_i && frame_start_i;

        if (sys_reset) begin
            valid_o       <= 1'b0;
            frame_start_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/depth_stream_pkg.sv */
`default_nettype none

package depth_stream_pkg;

    ////////////////////////////////////////
    // datapath widths
    localparam int PIXEL_W   = 8;
    localparam int COORD_W   = 16;
    localparam int GAIN_W    = 8;
    // gain is unsigned 4.4, so 16 means unity
    localparam int GAIN_FRAC = 4;

    ////////////////////////////////////////
    // command word and register map
    localparam int CMD_BYTES  = 6;
    localparam int CMD_CNT_W  = $clog2(CMD_BYTES);
    localparam int CMD_ADDR_W = 16;
    localparam int CMD_DATA_W = 32;
    localparam logic [CMD_CNT_W-1:0] CMD_LAST = CMD_CNT_W'(CMD_BYTES - 1);

    localparam logic [CMD_ADDR_W-1:0] ADDR_ROI_WIDTH  = 16'h0001;
    localparam logic [CMD_ADDR_W-1:0] ADDR_ROI_HEIGHT = 16'h0002;
    localparam logic [CMD_ADDR_W-1:0] ADDR_GAIN       = 16'h0003;

    localparam logic [COORD_W-1:0] DEFAULT_ROI_WIDTH  = 16'd490;
    localparam logic [COORD_W-1:0] DEFAULT_ROI_HEIGHT = 16'd450;
    localparam logic [GAIN_W-1:0]  DEFAULT_GAIN       = 8'd16;

    ////////////////////////////////////////
    // output buffering and framing
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;
    localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = FIFO_CNT_W'(FIFO_DEPTH);

    // "BIVFRAME", most significant byte goes out first
    localparam logic [63:0] MAGIC_NUM = 64'h4249_5646_5241_4D45;
    localparam int MAGIC_BYTES = 8;
    localparam int MAGIC_IDX_W = $clog2(MAGIC_BYTES) + 1;
    localparam logic [MAGIC_IDX_W-1:0] MAGIC_END = MAGIC_IDX_W'(MAGIC_BYTES);

    // filled a byte at a time, read back as address and data
    typedef union packed {
        logic [0:CMD_BYTES-1][PIXEL_W-1:0] bytes;
        struct packed {
            logic [CMD_ADDR_W-1:0] addr;
            logic [CMD_DATA_W-1:0] data;
        } fields;
    } cmd_word_u;

endpackage

`default_nettype wire

/* hdl/depth_stream_top.sv */
`timescale 1ns/10ps
`default_nettype none

module depth_stream_top (
    input  wire                                  core_clk,
    input  wire                                  sys_reset,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] cmd_byte_i,
    input  wire                                  cmd_valid_i,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] plus_i,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] minus_i,
    input  wire                                  pix_valid_i,
    input  wire                                  pix_sof_i,
    output logic [depth_stream_pkg::PIXEL_W-1:0] byte_o,
    output logic                                 byte_valid_o,
    input  wire                                  byte_stall_i,
    output logic                                 overflow_o
);

    ////////////////////////////////////////
    // command path
    depth_stream_pkg::cmd_word_u cmd_word;
    logic                        cmd_word_valid;

    logic [depth_stream_pkg::COORD_W-1:0] roi_width;
    logic [depth_stream_pkg::COORD_W-1:0] roi_height;
    logic [depth_stream_pkg::GAIN_W-1:0]  gain;

    command_assembler u_command_assembler (
        .core_clk        (core_clk),
        .sys_reset       (sys_reset),
        .cmd_byte_i      (cmd_byte_i),
        .cmd_valid_i     (cmd_valid_i),
        .cmd_word_o      (cmd_word),
        .cmd_word_valid_o(cmd_word_valid)
    );

    constants_regs u_constants_regs (
        .core_clk        (core_clk),
        .sys_reset       (sys_reset),
        .cmd_word_i      (cmd_word),
        .cmd_word_valid_i(cmd_word_valid),
        .roi_width_o     (roi_width),
        .roi_height_o    (roi_height),
        .gain_o          (gain)
    );

    ////////////////////////////////////////
    // pixel path
    logic [depth_stream_pkg::PIXEL_W-1:0] trk_plus;
    logic [depth_stream_pkg::PIXEL_W-1:0] trk_minus;
    logic                                 trk_valid;
    logic                                 trk_frame_start;

    logic [depth_stream_pkg::PIXEL_W-1:0] con_byte;
    logic                                 con_valid;
    logic                                 con_frame_start;

    pixel_position_tracker u_pixel_position_tracker (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .plus_i       (plus_i),
        .minus_i      (minus_i),
        .pix_valid_i  (pix_valid_i),
        .pix_sof_i    (pix_sof_i),
        .roi_width_i  (roi_width),
        .roi_height_i (roi_height),
        .plus_o       (trk_plus),
        .minus_o      (trk_minus),
        .valid_o      (trk_valid),
        .frame_start_o(trk_frame_start)
    );

    contrast_stage u_contrast_stage (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .plus_i       (trk_plus),
        .minus_i      (trk_minus),
        .valid_i      (trk_valid),
        .frame_start_i(trk_frame_start),
        .gain_i       (gain),
        .byte_o       (con_byte),
        .valid_o      (con_valid),
        .frame_start_o(con_frame_start)
    );

    ////////////////////////////////////////
    // buffering and output framing
    logic [depth_stream_pkg::PIXEL_W-1:0] fifo_byte;
    logic                                 fifo_frame_start;
    logic                                 fifo_valid;
    logic                                 fifo_pop;

    stream_fifo u_stream_fifo (
        .core_clk        (core_clk),
        .sys_reset       (sys_reset),
        .wr_byte_i       (con_byte),
        .wr_frame_start_i(con_frame_start),
        .wr_valid_i      (con_valid),
        .rd_pop_i        (fifo_pop),
        .rd_byte_o       (fifo_byte),
        .rd_frame_start_o(fifo_frame_start),
        .rd_valid_o      (fifo_valid),
        .overflow_o      (overflow_o)
    );

    frame_serializer u_frame_serializer (
        .core_clk        (core_clk),
        .sys_reset       (sys_reset),
        .rd_byte_i       (fifo_byte),
        .rd_frame_start_i(fifo_frame_start),
        .rd_valid_i      (fifo_valid),
        .rd_pop_o        (fifo_pop),
        .byte_o          (byte_o),
        .byte_valid_o    (byte_valid_o),
        .byte_stall_i    (byte_stall_i)
    );

endmodule

`default_nettype wire

/* hdl/frame_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_serializer (
    input  wire                                  core_clk,
    input  wire                                  sys_reset,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] rd_byte_i,
    input  wire                                  rd_frame_start_i,
    input  wire                                  rd_valid_i,
    output logic                                 rd_pop_o,
    output logic [depth_stream_pkg::PIXEL_W-1:0] byte_o,
    output logic                                 byte_valid_o,
    input  wire                                  byte_stall_i
);

    logic                                     out_free;
    logic                                     hdr_active_q;
    // counts header bytes already sent, zero while idle
    logic [depth_stream_pkg::MAGIC_IDX_W-1:0] hdr_idx_q;
    logic [depth_stream_pkg::PIXEL_W-1:0]     held_q;
    logic [depth_stream_pkg::PIXEL_W-1:0]     hdr_byte;

    // output register empty or handed off this cycle
    assign out_free = !byte_valid_o || !byte_stall_i;
    assign rd_pop_o = out_free && rd_valid_i && !hdr_active_q;

    assign hdr_byte = depth_stream_pkg::MAGIC_NUM[
        depth_stream_pkg::PIXEL_W *
        (depth_stream_pkg::MAGIC_BYTES - 1 - hdr_idx_q[depth_stream_pkg::MAGIC_IDX_W-2:0])
        +: depth_stream_pkg::PIXEL_W];

    ////////////////////////////////////////
    // output register and header playout
    always_ff @(posedge core_clk) begin
        if (out_free) begin
            if (hdr_active_q) begin
                byte_valid_o <= 1'b1;
                if (hdr_idx_q == depth_stream_pkg::MAGIC_END) begin
                    // header done, release the pixel that started it
                    byte_o       <= held_q;
                    hdr_active_q <= 1'b0;
                    hdr_idx_q    <= '0;
                end else begin
                    byte_o    <= hdr_byte;
                    hdr_idx_q <= hdr_idx_q + 1'b1;
                end
            end else if (rd_valid_i) begin
                byte_valid_o <= 1'b1;
                if (rd_frame_start_i) begin
                    // first magic byte goes out right away
                    held_q       <= rd_byte_i;
                    byte_o       <= hdr_byte;
                    hdr_active_q <= 1'b1;
                    hdr_idx_q    <= hdr_idx_q + 1'b1;
                end else begin
                    byte_o <= rd_byte_i;
                end
            end else begin
                byte_valid_o <= 1'b0;
            end
        end

        if (sys_reset) begin
            byte_valid_o <= 1'b0;
            hdr_active_q <= 1'b0;
            hdr_idx_q    <= '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/pixel_position_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_position_tracker (
    input  wire                                  core_clk,
    input  wire                                  sys_reset,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] plus_i,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] minus_i,
    input  wire                                  pix_valid_i,
    input  wire                                  pix_sof_i,
    input  wire  [depth_stream_pkg::COORD_W-1:0] roi_width_i,
    input  wire  [depth_stream_pkg::COORD_W-1:0] roi_height_i,
    output logic [depth_stream_pkg::PIXEL_W-1:0] plus_o,
    output logic [depth_stream_pkg::PIXEL_W-1:0] minus_o,
    output logic                                 valid_o,
    output logic                                 frame_start_o
);

    // position that the next valid pixel will take
    logic [depth_stream_pkg::COORD_W-1:0] col_q;
    logic [depth_stream_pkg::COORD_W-1:0] row_q;

    logic [depth_stream_pkg::COORD_W-1:0] cur_col;
    logic [depth_stream_pkg::COORD_W-1:0] cur_row;
    logic [depth_stream_pkg::COORD_W-1:0] col_next;
    logic [depth_stream_pkg::COORD_W-1:0] row_next;
    logic                                 at_origin;

    always_comb begin
        // source sof forces this pixel back to (0,0)
        cur_col   = pix_sof_i ? '0 : col_q;
        cur_row   = pix_sof_i ? '0 : row_q;
        at_origin = (cur_col == '0) && (cur_row == '0);

        col_next = cur_col + 1'b1;
        row_next = cur_row;
        // >= keeps counters sane if the region shrinks mid-frame
        if (cur_col >= roi_width_i - 1'b1) begin
            col_next = '0;
            row_next = cur_row + 1'b1;
            if (cur_row >= roi_height_i - 1'b1) begin
                row_next = '0;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        plus_o        <= plus_i;
        minus_o       <= minus_i;
        valid_o       <= pix_valid_i;
        frame_start_o <= pix_valid_i && at_origin;

        if (pix_valid_i) begin
            col_q <= col_next;
            row_q <= row_next;
        end

        if (sys_reset) begin
            valid_o       <= 1'b0;
            frame_start_o <= 1'b0;
            col_q         <= '0;
            row_q         <= '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/stream_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_fifo (
    input  wire                                  core_clk,
    input  wire                                  sys_reset,
    input  wire  [depth_stream_pkg::PIXEL_W-1:0] wr_byte_i,
    input  wire                                  wr_frame_start_i,
    input  wire                                  wr_valid_i,
    input  wire                                  rd_pop_i,
    output logic [depth_stream_pkg::PIXEL_W-1:0] rd_byte_o,
    output logic                                 rd_frame_start_o,
    output logic                                 rd_valid_o,
    output logic                                 overflow_o
);

    // entry is {frame_start, byte}
    logic [depth_stream_pkg::PIXEL_W:0]      mem_q [depth_stream_pkg::FIFO_DEPTH];
    logic [depth_stream_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
    logic [depth_stream_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
    logic [depth_stream_pkg::FIFO_CNT_W-1:0] count_q;

    logic full;
    logic do_wr;
    logic do_rd;

    assign full       = (count_q == depth_stream_pkg::FIFO_FULL);
    assign rd_valid_o = (count_q != '0);
    assign do_wr      = wr_valid_i && !full;
    assign do_rd      = rd_pop_i && rd_valid_o;

    assign {rd_frame_start_o, rd_byte_o} = mem_q[rd_ptr_q];

    always_ff @(posedge core_clk) begin
        if (do_wr) begin
            mem_q[wr_ptr_q] <= {wr_frame_start_i, wr_byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase

            // sticky until reset, the lost entry is gone
            if (wr_valid_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the depth stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    --top-module depth_stream_tb \
    --Mdir "$BUILD_DIR" -o depth_stream_sim \
    -f files.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/depth_stream_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
